//--- design/soc_map_pkg.sv
package soc_map_pkg;

    // Device select bytes, compared against address bits 31:24
    localparam logic [7:0] GPIO_BASE  = 8'h40;
    localparam logic [7:0] IRQ_BASE   = 8'h80;
    localparam logic [7:0] TIMER_BASE = 8'hc0;

    // Bit position of the device byte within the bus address
    localparam int DEV_SHIFT = 24;

    // Device addressed by the transfer in progress
    // DEV_NONE covers both idle and an unmapped address byte
    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_TIMER,
        DEV_GPIO,
        DEV_IRQ
    } dev_e;

endpackage

//--- design/soc_regs_pkg.sv
package soc_regs_pkg;

    // Register index, taken from address bits 3:2 in every device

    // Timer registers
    typedef enum logic [1:0] {
        TMR_COUNT = 2'd0,
        TMR_CMP   = 2'd1,
        TMR_CTRL  = 2'd2
    } timer_reg_e;

    // GPIO registers
    typedef enum logic [1:0] {
        GPIO_OUT  = 2'd0,
        GPIO_IN   = 2'd1,
        GPIO_CAPT = 2'd2
    } gpio_reg_e;

    // Interrupt controller registers
    typedef enum logic [1:0] {
        IRQ_PEND = 2'd0,
        IRQ_EN   = 2'd1
    } irq_reg_e;

    // Width of the GPIO port
    localparam int GPIO_W = 8;

    // Interrupt sources and their pending bit positions
    localparam int IRQ_N     = 2;
    localparam int IRQ_TIMER = 0;
    localparam int IRQ_GPIO  = 1;

endpackage

//--- design/bus_decode.sv
`timescale 1ns/1ns

module bus_decode (
    input  logic       ck,
    input  logic       RESET_LOOP,
    input  logic       i_cyc,
    input  logic [7:0] i_adr_dev,
    output logic       o_ack,
    output logic       o_timer_sel,
    output logic       o_gpio_sel,
    output logic       o_irq_sel
);
    import soc_map_pkg::*;

    dev_e dev_hit;
    dev_e dev_q;
    logic ack_q;

    // Address byte to device
    always_comb begin
        case (i_adr_dev)
            TIMER_BASE: dev_hit = DEV_TIMER;
            GPIO_BASE:  dev_hit = DEV_GPIO;
            IRQ_BASE:   dev_hit = DEV_IRQ;
            default:    dev_hit = DEV_NONE;
        endcase
    end

    // A transfer is taken only when no ack is in flight.
    // The master still holds cyc during the ack cycle, so this gives
    // exactly one ack per transfer
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            ack_q <= 1'b0;
            dev_q <= DEV_NONE;
        end else if (i_cyc && !ack_q) begin
            ack_q <= 1'b1;
            dev_q <= dev_hit;
        end else begin
            ack_q <= 1'b0;
            dev_q <= DEV_NONE;
        end
    end

    assign o_ack = ack_q;

    // Unmapped bytes leave dev_q at DEV_NONE, acked with no select
    assign o_timer_sel = (dev_q == DEV_TIMER);
    assign o_gpio_sel  = (dev_q == DEV_GPIO);
    assign o_irq_sel   = (dev_q == DEV_IRQ);

endmodule

//--- design/timer.sv
`timescale 1ns/1ns

module timer (
    input  logic                     ck,
    input  logic                     RESET_LOOP,
    input  logic                     i_sel,
    input  logic                     i_we,
    input  soc_regs_pkg::timer_reg_e i_reg,
    input  logic [31:0]              i_dat,
    output logic [31:0]              o_rdt,
    output logic                     o_timer_irq
);
    import soc_regs_pkg::*;

    logic [31:0] count_q;
    logic [31:0] cmp_q;
    logic        en_q;
    logic        irq_q;
    logic        wr;

    assign wr = i_sel && i_we;

    // Free-running counter, loaded by a write to TMR_COUNT
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            count_q <= '0;
        end else if (wr && (i_reg == TMR_COUNT)) begin
            count_q <= i_dat;
        end else if (en_q) begin
            count_q <= count_q + 32'd1;
        end
    end

    // Compare value and enable bit
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            cmp_q <= '0;
            en_q  <= 1'b0;
        end else if (wr) begin
            if (i_reg == TMR_CMP) begin
                cmp_q <= i_dat;
            end
            if (i_reg == TMR_CTRL) begin
                en_q <= i_dat[0];
            end
        end
    end

    // Level interrupt, held while the count has reached the compare
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= en_q && (count_q >= cmp_q);
        end
    end

    assign o_timer_irq = irq_q;

    // Read data is zero unless this device is selected
    always_comb begin
        o_rdt = '0;
        if (i_sel) begin
            case (i_reg)
                TMR_COUNT: o_rdt = count_q;
                TMR_CMP:   o_rdt = cmp_q;
                TMR_CTRL:  o_rdt = {31'd0, en_q};
                default:   o_rdt = '0;
            endcase
        end
    end

endmodule

//--- design/gpio.sv
`timescale 1ns/1ns

module gpio (
    input  logic                              ck,
    input  logic                              RESET_LOOP,
    input  logic                              i_sel,
    input  logic                              i_we,
    input  soc_regs_pkg::gpio_reg_e           i_reg,
    input  logic [31:0]                       i_dat,
    input  logic [soc_regs_pkg::GPIO_W-1:0]   i_pins,
    output logic [31:0]                       o_rdt,
    output logic [soc_regs_pkg::GPIO_W-1:0]   o_pins,
    output logic                              o_gpio_irq
);
    import soc_regs_pkg::*;

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] sync1_q;
    logic [GPIO_W-1:0] sync2_q;
    logic [GPIO_W-1:0] prev_q;
    logic [GPIO_W-1:0] capt_q;
    logic [GPIO_W-1:0] rise;
    logic [GPIO_W-1:0] clr;
    logic              irq_q;
    logic              wr;

    assign wr = i_sel && i_we;

    // Two-flop synchroniser, then one more stage for edge detection
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= i_pins;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise = sync2_q & ~prev_q;
    assign clr  = (wr && (i_reg == GPIO_CAPT)) ? i_dat[GPIO_W-1:0] : '0;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            out_q  <= '0;
            capt_q <= '0;
            irq_q  <= 1'b0;
        end else begin
            if (wr && (i_reg == GPIO_OUT)) begin
                out_q <= i_dat[GPIO_W-1:0];
            end
            // Set wins over a clear in the same cycle
            capt_q <= (capt_q & ~clr) | rise;
            irq_q  <= |capt_q;
        end
    end

    assign o_pins     = out_q;
    assign o_gpio_irq = irq_q;

    always_comb begin
        o_rdt = '0;
        if (i_sel) begin
            case (i_reg)
                GPIO_OUT:  o_rdt = {{(32-GPIO_W){1'b0}}, out_q};
                GPIO_IN:   o_rdt = {{(32-GPIO_W){1'b0}}, sync2_q};
                GPIO_CAPT: o_rdt = {{(32-GPIO_W){1'b0}}, capt_q};
                default:   o_rdt = '0;
            endcase
        end
    end

endmodule

//--- design/irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl (
    input  logic                   ck,
    input  logic                   RESET_LOOP,
    input  logic                   i_sel,
    input  logic                   i_we,
    input  soc_regs_pkg::irq_reg_e i_reg,
    input  logic [31:0]            i_dat,
    input  logic                   i_timer_irq,
    input  logic                   i_gpio_irq,
    output logic [31:0]            o_rdt,
    output logic                   o_irq
);
    import soc_regs_pkg::*;

    logic [IRQ_N-1:0] pend;
    logic [IRQ_N-1:0] en_q;
    logic             irq_q;

    // Pending is the live level of each source, not latched
    always_comb begin
        pend            = '0;
        pend[IRQ_TIMER] = i_timer_irq;
        pend[IRQ_GPIO]  = i_gpio_irq;
    end

    // Enable mask, read/write
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            en_q <= '0;
        end else if (i_sel && i_we && (i_reg == IRQ_EN)) begin
            en_q <= i_dat[IRQ_N-1:0];
        end
    end

    // Combined request, one cycle behind pending and enable
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(pend & en_q);
        end
    end

    assign o_irq = irq_q;

    always_comb begin
        o_rdt = '0;
        if (i_sel) begin
            case (i_reg)
                IRQ_PEND: o_rdt = {{(32-IRQ_N){1'b0}}, pend};
                IRQ_EN:   o_rdt = {{(32-IRQ_N){1'b0}}, en_q};
                default:  o_rdt = '0;
            endcase
        end
    end

endmodule

//--- design/periph_top.sv
`timescale 1ns/1ns

module periph_top (
    input  logic                            ck,
    input  logic                            RESET_LOOP,
    input  logic                            i_cyc,
    input  logic                            i_we,
    input  logic [31:0]                     i_adr,
    input  logic [31:0]                     i_dat,
    output logic                            o_ack,
    output logic [31:0]                     o_rdt,
    input  logic [soc_regs_pkg::GPIO_W-1:0] i_gpio,
    output logic [soc_regs_pkg::GPIO_W-1:0] o_gpio,
    output logic                            o_irq
);
    import soc_map_pkg::*;
    import soc_regs_pkg::*;

    logic [7:0]  adr_dev;
    logic [1:0]  adr_reg;
    logic        timer_sel;
    logic        gpio_sel;
    logic        irq_sel;
    logic [31:0] timer_rdt;
    logic [31:0] gpio_rdt;
    logic [31:0] irq_rdt;
    logic        timer_irq;
    logic        gpio_irq;

    // Device byte on top, word index in bits 3:2
    assign adr_dev = i_adr[DEV_SHIFT +: 8];
    assign adr_reg = i_adr[3:2];

    bus_decode bus_decode_inst (
        .ck          (ck),
        .RESET_LOOP  (RESET_LOOP),
        .i_cyc       (i_cyc),
        .i_adr_dev   (adr_dev),
        .o_ack       (o_ack),
        .o_timer_sel (timer_sel),
        .o_gpio_sel  (gpio_sel),
        .o_irq_sel   (irq_sel)
    );

    timer timer_inst (
        .ck          (ck),
        .RESET_LOOP  (RESET_LOOP),
        .i_sel       (timer_sel),
        .i_we        (i_we),
        .i_reg       (timer_reg_e'(adr_reg)),
        .i_dat       (i_dat),
        .o_rdt       (timer_rdt),
        .o_timer_irq (timer_irq)
    );

    gpio gpio_inst (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_sel      (gpio_sel),
        .i_we       (i_we),
        .i_reg      (gpio_reg_e'(adr_reg)),
        .i_dat      (i_dat),
        .i_pins     (i_gpio),
        .o_rdt      (gpio_rdt),
        .o_pins     (o_gpio),
        .o_gpio_irq (gpio_irq)
    );

    irq_ctrl irq_ctrl_inst (
        .ck          (ck),
        .RESET_LOOP  (RESET_LOOP),
        .i_sel       (irq_sel),
        .i_we        (i_we),
        .i_reg       (irq_reg_e'(adr_reg)),
        .i_dat       (i_dat),
        .i_timer_irq (timer_irq),
        .i_gpio_irq  (gpio_irq),
        .o_rdt       (irq_rdt),
        .o_irq       (o_irq)
    );

    // Each device drives zero when unselected
    assign o_rdt = timer_rdt | gpio_rdt | irq_rdt;

endmodule

//--- testbench/periph_props.sv
`timescale 1ns/1ns

module periph_props (
    input logic        ck,
    input logic        RESET_LOOP,
    input logic        i_cyc,
    input logic [31:0] i_adr,
    input logic        i_ack,
    input logic [31:0] i_rdt,
    input logic        i_irq,
    input logic        i_timer_sel,
    input logic        i_gpio_sel,
    input logic        i_irq_sel
);
    import soc_map_pkg::*;

    dev_e sel_dev;
    dev_e adr_dev;

    // Device named by the selects
    always_comb begin
        sel_dev = DEV_NONE;
        if (i_timer_sel) begin
            sel_dev = DEV_TIMER;
        end else if (i_gpio_sel) begin
            sel_dev = DEV_GPIO;
        end else if (i_irq_sel) begin
            sel_dev = DEV_IRQ;
        end
    end

    // Device named by the address byte on the bus
    always_comb begin
        case (i_adr[DEV_SHIFT +: 8])
            TIMER_BASE: adr_dev = DEV_TIMER;
            GPIO_BASE:  adr_dev = DEV_GPIO;
            IRQ_BASE:   adr_dev = DEV_IRQ;
            default:    adr_dev = DEV_NONE;
        endcase
    end

    ack_single: assert property (@(posedge ck) disable iff (RESET_LOOP) i_ack |=> !i_ack)
        else $error("ack high on two consecutive cycles");

    ack_after_cyc: assert property (@(posedge ck) disable iff (RESET_LOOP)
        i_ack |-> $past(i_cyc))
        else $error("ack without cyc sampled the cycle before");

    rdt_idle_zero: assert property (@(posedge ck) disable iff (RESET_LOOP)
        !i_ack |-> (i_rdt == 32'd0))
        else $error("read data not zero outside an ack");

    sel_of_adr: assert property (@(posedge ck) disable iff (RESET_LOOP)
        i_ack |-> (sel_dev == $past(adr_dev)))
        else $error("device select does not match the address of the transfer");

    irq_after_reset: assert property (@(posedge ck) $fell(RESET_LOOP) |-> !i_irq)
        else $error("interrupt request high right after reset");

endmodule

bind periph_top periph_props periph_props_inst (
    .ck          (ck),
    .RESET_LOOP  (RESET_LOOP),
    .i_cyc       (i_cyc),
    .i_adr       (i_adr),
    .i_ack       (o_ack),
    .i_rdt       (o_rdt),
    .i_irq       (o_irq),
    .i_timer_sel (timer_sel),
    .i_gpio_sel  (gpio_sel),
    .i_irq_sel   (irq_sel)
);

//--- testbench/tb_periph.sv
`timescale 1ns/1ns

module tb_periph;
    import soc_map_pkg::*;
    import soc_regs_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRV_DLY      = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          N_OPS        = 400;
    localparam int          ACK_LIMIT    = 4;
    localparam int          WATCHDOG_NS  = (N_OPS * 6 + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'he1110c3d;

    logic              ck = 1'b0;
    logic              RESET_LOOP;
    logic              i_cyc;
    logic              i_we;
    logic [31:0]       i_adr;
    logic [31:0]       i_dat;
    logic              o_ack;
    logic [31:0]       o_rdt;
    logic [GPIO_W-1:0] i_gpio;
    logic [GPIO_W-1:0] o_gpio;
    logic              o_irq;

    logic [31:0] rng_state;
    int          edge_n = 0;

    // Register model
    logic [31:0]       m_cmp;
    logic [31:0]       m_cnt_base;
    int                m_cnt_edge;
    logic              m_tmr_en;
    logic [GPIO_W-1:0] m_out;
    logic [GPIO_W-1:0] m_capt;
    logic [GPIO_W-1:0] m_pins;
    logic [IRQ_N-1:0]  m_irq_en;

    periph_top periph_top_inst (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_cyc      (i_cyc),
        .i_we       (i_we),
        .i_adr      (i_adr),
        .i_dat      (i_dat),
        .o_ack      (o_ack),
        .o_rdt      (o_rdt),
        .i_gpio     (i_gpio),
        .o_gpio     (o_gpio),
        .o_irq      (o_irq)
    );

    always #(CLK_PERIOD / 2) ck = ~ck;

    // Rising edges so far, used to time each ack
    always @(posedge ck) begin
        edge_n <= edge_n + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_rdt(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_pins(input string name, input logic [GPIO_W-1:0] exp,
                              input logic [GPIO_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("error %s o_gpio: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("error %s o_irq: expected %b, actual %b", name, exp, act));
        end
    endtask

    // LCG, upper halves of two steps
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi = rng_state[31:16];
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {hi, rng_state[31:16]};
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    // Count held after edge n
    function automatic logic [31:0] count_at(input int n);
        if (m_tmr_en) begin
            return m_cnt_base + 32'(n - m_cnt_edge);
        end else begin
            return m_cnt_base;
        end
    endfunction

    function automatic logic timer_src(input int n);
        return m_tmr_en && (count_at(n) >= m_cmp);
    endfunction

    function automatic logic gpio_src();
        return m_capt != '0;
    endfunction

    function automatic logic [7:0] base_of(input dev_e dev);
        case (dev)
            DEV_TIMER: return TIMER_BASE;
            DEV_GPIO:  return GPIO_BASE;
            DEV_IRQ:   return IRQ_BASE;
            default:   return 8'h00;
        endcase
    endfunction

    function automatic dev_e pick_dev();
        case (rand_below(3))
            0:       return DEV_TIMER;
            1:       return DEV_GPIO;
            default: return DEV_IRQ;
        endcase
    endfunction

    function automatic logic [7:0] unmapped_byte();
        logic [31:0] r;
        logic [7:0]  b;
        b = GPIO_BASE;
        while (b == GPIO_BASE || b == IRQ_BASE || b == TIMER_BASE) begin
            r = next_rand();
            b = r[31:24];
        end
        return b;
    endfunction

    // Random filler around the device byte and the word index
    function automatic logic [31:0] make_addr(input logic [7:0] dev_byte, input logic [1:0] idx);
        logic [31:0] r;
        r = next_rand();
        return {dev_byte, r[23:4], idx, r[1:0]};
    endfunction

    // Read value with the ack at edge r
    function automatic logic [31:0] expected_read(input dev_e dev, input logic [1:0] idx,
                                                  input int r);
        logic [31:0] v;
        v = '0;
        case (dev)
            DEV_TIMER: begin
                case (timer_reg_e'(idx))
                    TMR_COUNT: v = count_at(r);
                    TMR_CMP:   v = m_cmp;
                    TMR_CTRL:  v = {31'd0, m_tmr_en};
                    default:   v = '0;
                endcase
            end
            DEV_GPIO: begin
                case (gpio_reg_e'(idx))
                    GPIO_OUT:  v = 32'(m_out);
                    GPIO_IN:   v = 32'(m_pins);
                    GPIO_CAPT: v = 32'(m_capt);
                    default:   v = '0;
                endcase
            end
            DEV_IRQ: begin
                // Pending lags the source state by one register
                if (irq_reg_e'(idx) == IRQ_PEND) begin
                    v[IRQ_TIMER] = timer_src(r - 1);
                    v[IRQ_GPIO]  = gpio_src();
                end else if (irq_reg_e'(idx) == IRQ_EN) begin
                    v = 32'(m_irq_en);
                end
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    // Write acked at edge a takes effect at a + 1
    function automatic void update_model(input dev_e dev, input logic [1:0] idx,
                                         input logic [31:0] dat, input int a);
        if (dev == DEV_TIMER) begin
            if (timer_reg_e'(idx) == TMR_COUNT) begin
                m_cnt_base = dat;
                m_cnt_edge = a + 1;
            end else if (timer_reg_e'(idx) == TMR_CMP) begin
                m_cmp = dat;
            end else if (timer_reg_e'(idx) == TMR_CTRL) begin
                m_cnt_base = count_at(a + 1);
                m_cnt_edge = a + 1;
                m_tmr_en   = dat[0];
            end
        end else if (dev == DEV_GPIO) begin
            if (gpio_reg_e'(idx) == GPIO_OUT) begin
                m_out = dat[GPIO_W-1:0];
            end else if (gpio_reg_e'(idx) == GPIO_CAPT) begin
                m_capt = m_capt & ~dat[GPIO_W-1:0];
            end
        end else if (dev == DEV_IRQ && irq_reg_e'(idx) == IRQ_EN) begin
            m_irq_en = dat[IRQ_N-1:0];
        end
    endfunction

    task automatic next_edge();
        @(posedge ck);
        #DRV_DLY;
    endtask

    // Holds the request through the cycle after the ack
    task automatic bus_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                                output logic [31:0] rdt, output int ack_edge);
        int waited;
        i_cyc = 1'b1;
        i_we  = we;
        i_adr = adr;
        i_dat = dat;
        waited = 1;
        next_edge();
        while (o_ack !== 1'b1 && waited < ACK_LIMIT) begin
            next_edge();
            waited++;
        end
        if (o_ack !== 1'b1) begin
            fail_run($sformatf("no ack within %0d cycles for address %h", ACK_LIMIT, adr));
        end else begin
            rdt = o_rdt;
            ack_edge = edge_n;
            next_edge();
            i_cyc = 1'b0;
            i_we  = 1'b0;
        end
    endtask

    task automatic do_write(input logic [31:0] adr, input logic [31:0] dat, output int ack_edge);
        logic [31:0] ignored;
        bus_transfer(1'b1, adr, dat, ignored, ack_edge);
    endtask

    task automatic do_read(input logic [31:0] adr, output logic [31:0] rdt, output int ack_edge);
        bus_transfer(1'b0, adr, 32'd0, rdt, ack_edge);
    endtask

    // o_irq reflects the sources two edges back
    task automatic idle_then_verify(input int k, input string name);
        int   n;
        logic exp_irq;
        repeat (k) next_edge();
        n = edge_n;
        exp_irq = (timer_src(n - 2) & m_irq_en[IRQ_TIMER]) | (gpio_src() & m_irq_en[IRQ_GPIO]);
        check_irq(name, exp_irq, o_irq);
        check_pins(name, m_out, o_gpio);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the test finished");
    end

    initial begin
        int                kind;
        int                ack;
        dev_e              dev;
        logic [1:0]        idx;
        logic [31:0]       adr;
        logic [31:0]       dat;
        logic [31:0]       rdt;
        logic [31:0]       r;
        logic [GPIO_W-1:0] new_pins;
        string             name;

        RESET_LOOP = 1'b1;
        i_cyc      = 1'b0;
        i_we       = 1'b0;
        i_adr      = '0;
        i_dat      = '0;
        i_gpio     = '0;
        rng_state  = SEED;
        m_cmp      = '0;
        m_cnt_base = '0;
        m_cnt_edge = 0;
        m_tmr_en   = 1'b0;
        m_out      = '0;
        m_capt     = '0;
        m_pins     = '0;
        m_irq_en   = '0;

        repeat (RESET_CYCLES) @(posedge ck);
        #DRV_DLY;
        RESET_LOOP = 1'b0;
        m_cnt_edge = edge_n;
        check_irq("reset", 1'b0, o_irq);
        check_pins("reset", '0, o_gpio);

        for (int op = 0; op < N_OPS; op++) begin
            kind = rand_below(16);
            if (kind < 6) begin
                dev = pick_dev();
                idx = 2'(rand_below(4));
                dat = next_rand();
                do_write(make_addr(base_of(dev), idx), dat, ack);
                update_model(dev, idx, dat, ack);
                name = $sformatf("op %0d write %s reg %0d", op, dev.name(), idx);
                idle_then_verify(2, name);
            end else if (kind < 11) begin
                dev = pick_dev();
                idx = 2'(rand_below(4));
                do_read(make_addr(base_of(dev), idx), rdt, ack);
                name = $sformatf("op %0d read %s reg %0d", op, dev.name(), idx);
                check_rdt(name, expected_read(dev, idx, ack), rdt);
            end else if (kind == 11) begin
                adr = make_addr(unmapped_byte(), 2'(rand_below(4)));
                if (rand_below(2) == 0) begin
                    do_write(adr, next_rand(), ack);
                    idle_then_verify(2, $sformatf("op %0d unmapped write %h", op, adr));
                end else begin
                    do_read(adr, rdt, ack);
                    check_rdt($sformatf("op %0d unmapped read %h", op, adr), 32'd0, rdt);
                end
            end else if (kind < 14) begin
                // New pin pattern, held until it has passed the synchroniser
                r = next_rand();
                new_pins = r[GPIO_W-1:0];
                i_gpio = new_pins;
                m_capt = m_capt | (new_pins & ~m_pins);
                m_pins = new_pins;
                repeat (3) next_edge();
                idle_then_verify(2, $sformatf("op %0d pins %h", op, new_pins));
            end else begin
                idle_then_verify(2 + rand_below(4), $sformatf("op %0d idle", op));
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- filelist.f
design/soc_map_pkg.sv
design/soc_regs_pkg.sv
design/bus_decode.sv
design/timer.sv
design/gpio.sv
design/irq_ctrl.sv
design/periph_top.sv
testbench/periph_props.sv
testbench/tb_periph.sv

//--- Makefile
# Verilator flow for the peripheral bus testbench
# The simulator exits non-zero when the testbench ends in $fatal

TOP := tb_periph

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
